/* common/display_pkg.sv */
// ----------------------------------------------------------
// display geometry
// tile grid, entity slot counts and the default scan timing
// for a 640x480 vga raster
// ----------------------------------------------------------
package display_pkg;

    // sprite edge in source pixels
    localparam int TILE_SIZE      = 8;

    // visible grid in tiles
    localparam int SCREEN_TILES_H = 16;
    localparam int SCREEN_TILES_V = 12;

    // entity table size; the top two slots draw their rows mirrored
    localparam int NUM_SLOTS      = 9;
    localparam int NUM_FLIP_SLOTS = 2;

    // screen pixels per sprite pixel
    localparam int UPSCALE_DEF    = 5;

    // horizontal timing in pixel clocks
    localparam int H_ACTIVE_DEF   = 640;
    localparam int H_FRONT_DEF    = 16;
    localparam int H_SYNC_DEF     = 96;
    localparam int H_BACK_DEF     = 48;

    // vertical timing in lines
    localparam int V_ACTIVE_DEF   = 480;
    localparam int V_FRONT_DEF    = 10;
    localparam int V_SYNC_DEF     = 2;
    localparam int V_BACK_DEF     = 33;

endpackage

/* common/entity_pkg.sv */
// ----------------------------------------------------------
// entity records
// table entry and detector result formats, plus the sprite
// glyph rule and the colour palette
// ----------------------------------------------------------
package entity_pkg;

    // id of an unused slot
    localparam logic [3:0] ID_NONE = 4'hf;

    // loc[3:0] is the tile column, loc[7:4] the tile row
    typedef struct packed {
        logic [3:0] id;
        logic [1:0] orient;
        logic [7:0] loc;
    } entity_t;

    localparam entity_t ENTITY_NONE = '{id: ID_NONE, orient: 2'b00, loc: 8'h00};

    // row label of the entity under the beam
    typedef struct packed {
        logic [2:0] row;
        logic [3:0] id;
        logic [1:0] orient;
    } det_t;

    // all ones means nothing under the beam
    localparam det_t DET_NONE = '1;

    typedef enum logic [1:0] {
        GLYPH_SOLID   = 2'd0,
        GLYPH_FRAME   = 2'd1,
        GLYPH_DIAG    = 2'd2,
        GLYPH_CHECKER = 2'd3
    } glyph_e;

    // low two id bits pick the glyph
    function automatic glyph_e glyph_of(input logic [3:0] id);
        return glyph_e'(id[1:0]);
    endfunction

    // lit test for one sprite pixel, written straight from the glyph rule
    function automatic logic pattern_bit(input logic [3:0] id, input logic [2:0] row,
                                         input logic [2:0] col);
        logic lit;
        case (glyph_of(id))
            GLYPH_SOLID: lit = 1'b1;
            GLYPH_FRAME: lit = (row == 3'd0) || (row == 3'd7) || (col == 3'd0) || (col == 3'd7);
            GLYPH_DIAG:  lit = (col == row);
            default:     lit = row[0] ^ col[0];
        endcase
        return lit;
    endfunction

    // id bits 2:0, with black remapped to white
    function automatic logic [2:0] palette(input logic [3:0] id);
        return (id[2:0] == 3'd0) ? 3'd7 : id[2:0];
    endfunction

endpackage

/* common/scan_if.sv */
// ----------------------------------------------------------
// scan bus
// beam position, blanking and sync levels from the timing
// generator to the rest of the display pipeline
// ----------------------------------------------------------
`timescale 1ns/1ps

interface scan_if;

    // pixel and line counters
    logic [9:0] h_count;
    logic [9:0] v_count;
    // beam inside the visible area
    logic       active;
    // sync levels, active low
    logic       hsync;
    logic       vsync;
    // one cycle on the last pixel of the last line
    logic       frame_end;

    modport source (output h_count, v_count, active, hsync, vsync, frame_end);
    modport sink   (input  h_count, v_count, active, hsync, vsync, frame_end);

endinterface

/* compile.f */
common/display_pkg.sv
common/entity_pkg.sv
common/scan_if.sv
rtl/scan_timing.sv
entity_detect/entity_detect.sv
rtl/frame_control.sv
rtl/sprite_rom.sv
rtl/pixel_out.sv
rtl/tile_display_top.sv
test/tile_display_tb.sv

/* entity_detect/entity_detect.sv */
// ----------------------------------------------------------
// entity detector
// tests the beam against every table slot and returns the
// row label of the entity under it, lowest slot first
// ----------------------------------------------------------
`timescale 1ns/1ps

module entity_detect
    import display_pkg::*, entity_pkg::*;
#(
    parameter int UPSCALE = UPSCALE_DEF
) (
    scan_if.sink    scan,
    input  entity_t entities [NUM_SLOTS],
    output det_t    det
);

    // tile edge in screen pixels
    localparam int TILE_PIX  = TILE_SIZE * UPSCALE;
    // first slot that draws its rows upside down
    localparam int FLIP_BASE = NUM_SLOTS - NUM_FLIP_SLOTS;

    det_t slot_det [NUM_SLOTS];

    // hit test and row label for one slot, DET_NONE on a miss
    function automatic det_t probe(input entity_t ent, input logic [9:0] h,
                                   input logic [9:0] v, input logic flip);
        int         org_h;
        int         org_v;
        logic [2:0] row;
        det_t       res;
        // tile origin in screen pixels
        org_h = int'(ent.loc[3:0]) * TILE_PIX;
        org_v = int'(ent.loc[7:4]) * TILE_PIX;
        res   = DET_NONE;
        if ((ent.id != ID_NONE) &&
            (int'(h) >= org_h) && (int'(h) < org_h + TILE_PIX) &&
            (int'(v) >= org_v) && (int'(v) < org_v + TILE_PIX))
        begin
            // sprite row from the line offset inside the tile
            row = 3'((int'(v) - org_v) / UPSCALE);
            // flip slots mirror vertically
            if (flip)
            begin
                row = ~row;
            end
            // orient bit 1 mirrors again, so a flip slot with it set shows upright
            if (ent.orient[1])
            begin
                row = ~row;
            end
            res = '{row: row, id: ent.id, orient: ent.orient};
        end
        return res;
    endfunction

    for (genvar s = 0; s < NUM_SLOTS; s++)
    begin : g_slot
        assign slot_det[s] = probe(entities[s], scan.h_count, scan.v_count,
                                   1'(s >= FLIP_BASE));
    end

    // priority merge
    // walk down from the top slot so a lower slot overrides any hit above it
    always_comb
    begin
        det = DET_NONE;
        if (scan.active)
        begin
            for (int i = NUM_SLOTS - 1; i >= 0; i--)
            begin
                if (slot_det[i].id != ID_NONE)
                begin
                    det = slot_det[i];
                end
            end
        end
    end

endmodule

/* rtl/frame_control.sv */
// ----------------------------------------------------------
// frame controller
// double-buffered entity table: software writes the shadow
// bank, the active bank reloads from it at frame end
// ----------------------------------------------------------
`timescale 1ns/1ps

module frame_control
    import display_pkg::*, entity_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    scan_if.sink       scan,
    input  logic       wr_en,
    input  logic [3:0] wr_slot,
    input  entity_t    wr_entity,
    output entity_t    active_table [NUM_SLOTS]
);

    // shadow bank, written at any time
    entity_t [NUM_SLOTS-1:0] shadow_q;
    // shadow bank as it reads after this edge
    entity_t [NUM_SLOTS-1:0] shadow_next;
    logic                    wr_valid;

    // slots past the table end are dropped
    assign wr_valid = wr_en && (wr_slot < 4'(NUM_SLOTS));

    // merge the write so a write on the swap cycle reaches both banks
    always_comb
    begin
        shadow_next = shadow_q;
        if (wr_valid)
        begin
            shadow_next[wr_slot] = wr_entity;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_SLOTS; i++)
            begin
                shadow_q[i] <= ENTITY_NONE;
            end
        end
        else
        begin
            shadow_q <= shadow_next;
        end
    end

    // active bank
    // only loads on the last cycle of a frame, so a frame never sees a partial update
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_SLOTS; i++)
            begin
                active_table[i] <= ENTITY_NONE;
            end
        end
        else if (scan.frame_end)
        begin
            for (int i = 0; i < NUM_SLOTS; i++)
            begin
                active_table[i] <= shadow_next[i];
            end
        end
    end

    // an out of range slot leaves the whole shadow bank untouched
    a_slot_range: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && (wr_slot >= 4'(NUM_SLOTS))) |=> $stable(shadow_q));

endmodule

/* rtl/pixel_out.sv */
// ----------------------------------------------------------
// pixel output stage
// two-stage pipeline from detector label to colour, with the
// syncs and data enable delayed to stay aligned
// ----------------------------------------------------------
`timescale 1ns/1ps

module pixel_out
    import display_pkg::*, entity_pkg::*;
#(
    parameter int UPSCALE = UPSCALE_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    scan_if.sink       scan,
    input  det_t       det,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [2:0] rgb
);

    localparam int TILE_PIX = TILE_SIZE * UPSCALE;

    logic [2:0] col;
    det_t       det_s1;
    logic [2:0] col_s1;
    logic       hsync_s1;
    logic       vsync_s1;
    logic       de_s1;
    det_t       det_s2;
    logic [2:0] col_s2;
    logic [7:0] pattern;
    logic [2:0] col_sel;
    logic       lit;

    // tiles start on tile-size multiples, so no origin is needed
    assign col = 3'((int'(scan.h_count) % TILE_PIX) / UPSCALE);

    // stage 1, detector result and scan levels
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            det_s1   <= DET_NONE;
            hsync_s1 <= 1'b1;
            vsync_s1 <= 1'b1;
            de_s1    <= 1'b0;
        end
        else
        begin
            det_s1   <= det;
            hsync_s1 <= scan.hsync;
            vsync_s1 <= scan.vsync;
            de_s1    <= scan.active;
        end
    end

    // stage 2, pattern row lands here alongside the delayed levels
    sprite_rom i_rom (
        .clk     (clk),
        .id      (det_s1.id),
        .row     (det_s1.row),
        .pattern (pattern)
    );

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            det_s2 <= DET_NONE;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            de     <= 1'b0;
        end
        else
        begin
            det_s2 <= det_s1;
            hsync  <= hsync_s1;
            vsync  <= vsync_s1;
            de     <= de_s1;
        end
    end

    // column offset within the tile, delayed to meet the pattern row
    always_ff @(posedge clk)
    begin
        col_s1 <= col;
        col_s2 <= col_s1;
    end

    // orient bit 0 mirrors columns
    assign col_sel = det_s2.orient[0] ? ~col_s2 : col_s2;
    assign lit     = de && (det_s2.id != ID_NONE) && pattern[col_sel];
    assign rgb     = lit ? palette(det_s2.id) : 3'd0;

endmodule

/* rtl/scan_timing.sv */
// ----------------------------------------------------------
// scan timing generator
// pixel and line counters, visible area flag, hsync/vsync
// levels and the end of frame pulse, one pixel per clock
// ----------------------------------------------------------
`timescale 1ns/1ps

module scan_timing
    import display_pkg::*;
#(
    parameter int H_ACTIVE = H_ACTIVE_DEF,
    parameter int H_FRONT  = H_FRONT_DEF,
    parameter int H_SYNC   = H_SYNC_DEF,
    parameter int H_BACK   = H_BACK_DEF,
    parameter int V_ACTIVE = V_ACTIVE_DEF,
    parameter int V_FRONT  = V_FRONT_DEF,
    parameter int V_SYNC   = V_SYNC_DEF,
    parameter int V_BACK   = V_BACK_DEF
) (
    input  logic   clk,
    input  logic   rst_n,
    scan_if.source scan
);

    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    // sync windows sit right after the front porch
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    logic h_last;
    logic v_last;

    assign h_last = (scan.h_count == 10'(H_TOTAL - 1));
    assign v_last = (scan.v_count == 10'(V_TOTAL - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scan.h_count <= '0;
            scan.v_count <= '0;
        end
        else if (h_last)
        begin
            scan.h_count <= '0;
            // line counter steps once per line and wraps after the last one
            scan.v_count <= v_last ? 10'd0 : scan.v_count + 10'd1;
        end
        else
        begin
            scan.h_count <= scan.h_count + 10'd1;
        end
    end

    // levels decoded straight from the counters, so they line up with them
    assign scan.active = (scan.h_count < 10'(H_ACTIVE)) && (scan.v_count < 10'(V_ACTIVE));
    assign scan.hsync  = !((scan.h_count >= 10'(H_SYNC_START)) &&
                           (scan.h_count <  10'(H_SYNC_END)));
    assign scan.vsync  = !((scan.v_count >= 10'(V_SYNC_START)) &&
                           (scan.v_count <  10'(V_SYNC_END)));
    assign scan.frame_end = h_last && v_last;

    a_h_range: assert property (@(posedge clk) disable iff (!rst_n)
        scan.h_count < 10'(H_TOTAL));

    // frame end must never stretch into the first pixel of the next frame
    a_frame_end_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        scan.frame_end |=> !scan.frame_end);

endmodule

/* rtl/sprite_rom.sv */
// ----------------------------------------------------------
// sprite pattern table
// one 8-pixel row of a glyph per lookup, registered, bit n
// of the pattern is sprite column n
// ----------------------------------------------------------
`timescale 1ns/1ps

module sprite_rom
    import entity_pkg::*;
(
    input  logic       clk,
    input  logic [3:0] id,
    input  logic [2:0] row,
    output logic [7:0] pattern
);

    logic [7:0] row_bits;

    // glyph table, four shapes selected by the low id bits
    always_comb
    begin
        case (glyph_of(id))
            GLYPH_SOLID:
            begin
                // every pixel lit
                row_bits = 8'hff;
            end
            GLYPH_FRAME:
            begin
                // full top and bottom rows, edge pixels elsewhere
                if ((row == 3'd0) || (row == 3'd7))
                begin
                    row_bits = 8'hff;
                end
                else
                begin
                    row_bits = 8'h81;
                end
            end
            GLYPH_DIAG:
            begin
                // single pixel where column equals row
                row_bits = 8'h01 << row;
            end
            default:
            begin
                // checker, lit on odd row+col
                // even rows light odd columns
                row_bits = row[0] ? 8'h55 : 8'haa;
            end
        endcase
    end

    // one cycle of latency, matches the pipeline stage in pixel_out
    always_ff @(posedge clk)
    begin
        pattern <= row_bits;
    end

endmodule

/* rtl/tile_display_top.sv */
// ----------------------------------------------------------
// tile display engine
// scan timing, double-buffered entity table, entity detector
// and pixel pipeline; outputs lag the counters by 2 clocks
// ----------------------------------------------------------
`timescale 1ns/1ps

module tile_display_top
    import display_pkg::*, entity_pkg::*;
#(
    parameter int UPSCALE  = UPSCALE_DEF,
    parameter int H_ACTIVE = H_ACTIVE_DEF,
    parameter int H_FRONT  = H_FRONT_DEF,
    parameter int H_SYNC   = H_SYNC_DEF,
    parameter int H_BACK   = H_BACK_DEF,
    parameter int V_ACTIVE = V_ACTIVE_DEF,
    parameter int V_FRONT  = V_FRONT_DEF,
    parameter int V_SYNC   = V_SYNC_DEF,
    parameter int V_BACK   = V_BACK_DEF
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [3:0] wr_slot,
    input  entity_t    wr_entity,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [2:0] rgb
);

    scan_if  i_scan ();
    // table seen by the detector for the current frame
    entity_t active_table [NUM_SLOTS];
    det_t    det;

    scan_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .scan  (i_scan.source)
    );

    frame_control i_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan         (i_scan.sink),
        .wr_en        (wr_en),
        .wr_slot      (wr_slot),
        .wr_entity    (wr_entity),
        .active_table (active_table)
    );

    entity_detect #(.UPSCALE (UPSCALE)) i_detect (
        .scan     (i_scan.sink),
        .entities (active_table),
        .det      (det)
    );

    pixel_out #(.UPSCALE (UPSCALE)) i_pixel (
        .clk   (clk),
        .rst_n (rst_n),
        .scan  (i_scan.sink),
        .det   (det),
        .hsync (hsync),
        .vsync (vsync),
        .de    (de),
        .rgb   (rgb)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the tile display testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tile_display_tb \
    -f compile.f -o tile_display_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tile_display_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
# the run fails when the log holds the fail message
grep -q "Testbench failed" sim.log && exit 1 || exit 0

/* test/tile_display_tb.sv */
// ----------------------------------------------------------
// tile display testbench
// drives entity table writes from a stimulus table, follows
// each checked frame from de and the syncs, and compares rgb
// against a pixel model of the glyph and priority rules
// ----------------------------------------------------------
`timescale 1ns/1ps

module tile_display_tb;

    localparam int H_ACT        = 128;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 4;
    localparam int V_ACT        = 96;
    localparam int V_FRONT      = 4;
    localparam int V_SYNC       = 8;
    localparam int V_BACK       = 4;
    localparam int H_TOTAL      = H_ACT + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * (V_ACT + V_FRONT + V_SYNC + V_BACK);
    localparam int NUM_ROWS     = 8;
    localparam int SLOTS        = 9;
    // id 15 with orient and location zero marks an empty slot
    localparam logic [13:0] EMPTY = 14'h3c00;

    logic        clk;
    logic        rst_n;
    logic        wr_en;
    logic [3:0]  wr_slot;
    logic [13:0] wr_entity;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [2:0]  rgb;

    // stimulus table, one row per checked frame
    int          row_nw   [NUM_ROWS];
    logic [3:0]  row_slot [NUM_ROWS][SLOTS];
    logic [13:0] row_ent  [NUM_ROWS][SLOTS];
    logic        row_mid  [NUM_ROWS];

    // model copies of both table banks
    logic [13:0] shadow_ent [SLOTS];
    logic [13:0] active_ent [SLOTS];

    integer seed = 32'hb665bec2;
    int     rgb_errs;
    int     other_errs;
    logic   hung;

    tile_display_top #(
        .UPSCALE (1),
        .H_ACTIVE (H_ACT), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACT), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_slot   (wr_slot),
        .wr_entity (wr_entity),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .rgb       (rgb)
    );

    // 4 ns clock period
    always #2 clk = ~clk;

    // entity word is id, orient, tile row, tile column
    function automatic logic [13:0] make_entity(input int id, input int ori, input int trow,
                                                input int tcol);
        return {4'(id), 2'(ori), 4'(trow), 4'(tcol)};
    endfunction

    task automatic add_write(input int r, input int slot, input logic [13:0] ent);
        row_slot[r][row_nw[r]] = 4'(slot);
        row_ent[r][row_nw[r]]  = ent;
        row_nw[r]++;
    endtask

    task automatic add_random_row(input int r);
        int          off;
        logic [31:0] rnd;
        // each slot gets its own tile row, all shifted by one offset, so nothing overlaps
        off = int'($unsigned($random(seed)) % 32'd4);
        for (int s = 0; s < SLOTS; s++)
        begin
            rnd = $random(seed);
            add_write(r, s, make_entity(int'(rnd[3:0]), int'(rnd[5:4]), s + off,
                                        int'(rnd[11:8])));
        end
    endtask

    task automatic build_table;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            row_nw[r]  = 0;
            row_mid[r] = 1'b0;
        end
        // row 0 empty, a blank frame
        // row 1, all four glyphs and a few colours
        add_write(1, 0, make_entity(0, 0, 1, 1));
        add_write(1, 1, make_entity(1, 0, 1, 3));
        add_write(1, 2, make_entity(2, 0, 1, 5));
        add_write(1, 3, make_entity(3, 0, 1, 7));
        add_write(1, 4, make_entity(4, 0, 2, 2));
        add_write(1, 5, make_entity(13, 0, 2, 9));
        // row 2 is written mid-frame, in the lower half where an early swap would show
        row_mid[2] = 1'b1;
        add_write(2, 0, make_entity(6, 0, 8, 4));
        add_write(2, 1, EMPTY);
        add_write(2, 2, make_entity(7, 0, 8, 10));
        add_write(2, 3, EMPTY);
        // row 3, column and row mirroring, flip slots
        add_write(3, 0, make_entity(2, 1, 3, 2));
        add_write(3, 1, make_entity(6, 2, 3, 4));
        add_write(3, 2, make_entity(11, 3, 3, 6));
        for (int s = 3; s < 7; s++)
        begin
            add_write(3, s, EMPTY);
        end
        add_write(3, 7, make_entity(10, 0, 5, 2));
        // flip slot plus orient bit 1 shows upright
        add_write(3, 8, make_entity(14, 2, 5, 4));
        // row 4, overlapping slots
        add_write(4, 0, EMPTY);
        add_write(4, 1, make_entity(3, 0, 6, 6));
        add_write(4, 2, make_entity(2, 0, 6, 6));
        add_write(4, 3, make_entity(15, 0, 7, 7));
        add_write(4, 4, make_entity(5, 0, 7, 7));
        add_write(4, 5, EMPTY);
        add_write(4, 6, make_entity(4, 0, 9, 9));
        add_write(4, 7, make_entity(9, 0, 9, 9));
        add_write(4, 8, EMPTY);
        // row 5, slots past the table end only
        add_write(5, 9, make_entity(0, 0, 0, 0));
        add_write(5, 12, make_entity(1, 0, 1, 1));
        add_write(5, 15, make_entity(3, 0, 6, 6));
        add_random_row(6);
        add_random_row(7);
    endtask

    // colour at a visible pixel from the active model table
    function automatic logic [2:0] expected_rgb(input int x, input int y);
        int         id;
        int         ori;
        int         r;
        int         c;
        logic       lit;
        logic       found;
        logic [2:0] colour;
        colour = 3'd0;
        found  = 1'b0;
        lit    = 1'b0;
        for (int s = 0; s < SLOTS; s++)
        begin
            id  = int'(active_ent[s][13:10]);
            ori = int'(active_ent[s][9:8]);
            // lowest matching slot decides, lit or not
            if (!found && id != 15 && x / 8 == int'(active_ent[s][3:0]) &&
                y / 8 == int'(active_ent[s][7:4]))
            begin
                found = 1'b1;
                r = y % 8;
                c = x % 8;
                if (s >= SLOTS - 2)
                    r = 7 - r;
                if ((ori & 2) != 0)
                    r = 7 - r;
                if ((ori & 1) != 0)
                    c = 7 - c;
                case (id % 4)
                    0:       lit = 1'b1;
                    1:       lit = (r == 0) || (r == 7) || (c == 0) || (c == 7);
                    2:       lit = (c == r);
                    default: lit = ((r + c) % 2 == 1);
                endcase
                if (lit)
                    colour = (id % 8 == 0) ? 3'd7 : 3'(id % 8);
            end
        end
        return colour;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("error: %s expected 0x%h got 0x%h", name, exp, act);
            other_errs++;
        end
    endtask

    // one write port cycle; the model shadow bank follows valid slots
    task automatic apply_write(input logic [3:0] slot, input logic [13:0] ent);
        wr_en     = 1'b1;
        wr_slot   = slot;
        wr_entity = ent;
        if (slot < 4'd9)
            shadow_ent[slot] = ent;
    endtask

    task automatic drive_writes(input int r);
        for (int k = 0; k < row_nw[r]; k++)
        begin
            @(posedge clk);
            #1;
            apply_write(row_slot[r][k], row_ent[r][k]);
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic wait_vsync(input logic level);
        int n;
        n = 0;
        while (!hung && vsync !== level && n < FRAME_CYCLES * 2)
        begin
            @(negedge clk);
            n++;
        end
        if (!hung && vsync !== level)
        begin
            $display("timed out waiting for vsync to reach level %0d", level);
            other_errs++;
            hung = 1'b1;
        end
    endtask

    // follows one frame from the vsync rise to the next vsync fall
    task automatic check_frame(input int mid_row);
        int         x;
        int         y;
        int         de_count;
        int         n;
        int         wk;
        int         h_pos;
        int         line;
        logic       synced;
        logic       prev_de;
        logic       exp_hsync;
        logic [2:0] exp_rgb;
        x        = 0;
        y        = 0;
        de_count = 0;
        n        = 0;
        wk       = 0;
        h_pos    = 0;
        line     = 0;
        synced   = 1'b0;
        prev_de  = 1'b0;
        while (!hung && vsync === 1'b1 && n < FRAME_CYCLES * 2)
        begin
            @(posedge clk);
            #1;
            // next row's writes land in the lower half of this frame
            if (mid_row >= 0 && y >= V_ACT / 2 && wk < row_nw[mid_row])
            begin
                apply_write(row_slot[mid_row][wk], row_ent[mid_row][wk]);
                wk++;
            end
            else
                wr_en = 1'b0;
            @(negedge clk);
            n++;
            // raster position counts from the first de rise of the frame
            if (synced)
            begin
                h_pos++;
                if (h_pos == H_TOTAL)
                begin
                    h_pos = 0;
                    line++;
                end
            end
            else if (de && !prev_de)
            begin
                synced = 1'b1;
            end
            // hsync pulse follows the front porch of each line
            if (synced)
            begin
                exp_hsync = !((h_pos >= H_ACT + H_FRONT) && (h_pos < H_ACT + H_FRONT + H_SYNC));
                check_value("hsync", 32'(exp_hsync), 32'(hsync));
            end
            if (de)
            begin
                exp_rgb = expected_rgb(x, y);
                assert (rgb === exp_rgb)
                else
                begin
                    $display("error: rgb at x %0d y %0d expected 0x%h got 0x%h",
                             x, y, exp_rgb, rgb);
                    rgb_errs++;
                end
                x++;
                de_count++;
            end
            else
            begin
                check_value("rgb in blanking", 32'd0, 32'(rgb));
                // falling de closes a line
                if (prev_de)
                begin
                    x = 0;
                    y++;
                end
            end
            prev_de = de;
        end
        if (!hung && vsync === 1'b1)
        begin
            $display("timed out following a frame, vsync never fell");
            other_errs++;
            hung = 1'b1;
        end
        check_value("de count", 32'(H_ACT * V_ACT), 32'(de_count));
        // vsync falls on the first pixel after the vertical front porch
        check_value("vsync fall line", 32'(V_ACT + V_FRONT), 32'(line));
        check_value("vsync fall pixel", 32'd0, 32'(h_pos));
    endtask

    initial
    begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_slot    = 4'd0;
        wr_entity  = 14'd0;
        rgb_errs   = 0;
        other_errs = 0;
        hung       = 1'b0;
        for (int s = 0; s < SLOTS; s++)
        begin
            shadow_ent[s] = EMPTY;
            active_ent[s] = EMPTY;
        end
        build_table();
        repeat (2) @(posedge clk);
        #1;
        // reset levels before release
        check_value("hsync", 32'd1, 32'(hsync));
        check_value("vsync", 32'd1, 32'(vsync));
        check_value("de", 32'd0, 32'(de));
        check_value("rgb", 32'd0, 32'(rgb));
        rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (!row_mid[r])
                drive_writes(r);
            // next vsync fall, then its rise
            wait_vsync(1'b0);
            wait_vsync(1'b1);
            // the bank swap at the coming frame end precedes the first visible line
            for (int s = 0; s < SLOTS; s++)
            begin
                active_ent[s] = shadow_ent[s];
            end
            check_frame((r + 1 < NUM_ROWS && row_mid[r + 1]) ? r + 1 : -1);
        end
        $display("rgb errors %0d, other errors %0d", rgb_errs, other_errs);
        if (rgb_errs == 0 && other_errs == 0 && !hung)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
